// File: include/cpu_settings.svh
// Core sizing macros; CPU_REG_AW must match CPU_NUM_REGS, and the 16-bit ISA fields assume 8 regs
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and program counter width
`define CPU_DATA_W 16

// Register file size and index width
`define CPU_NUM_REGS 8
`define CPU_REG_AW 3

// Written by BL, read back by BX
`define CPU_LINK_REG 7

`endif

// File: rtl/cpuPkg.sv
// Encodings shared by the decoder and the datapath; enum widths are fixed by the control ports
package cpuPkg;

	// ALU operation; aluShift forwards the shifter so flags follow it
	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOrr   = 3'd3,
		aluEor   = 3'd4,
		aluMvn   = 3'd5,
		aluMov   = 3'd6,
		aluShift = 3'd7
	} aluOpT;

	// Barrel shifter kind
	typedef enum logic [1:0] {
		shLsl = 2'd0,
		shLsr = 2'd1,
		shAsr = 2'd2,
		shRor = 2'd3
	} shiftKindT;

	// Register write-back source
	typedef enum logic [2:0] {
		wrShift = 3'd0,
		wrAlu   = 3'd1,
		wrImm   = 3'd2,
		wrMem   = 3'd3,
		wrLink  = 3'd4
	} wrSelT;

	// Next pc source
	typedef enum logic [2:0] {
		brSeq    = 3'd0,
		brCond   = 3'd1,
		brUncond = 3'd2,
		brLink   = 3'd3,
		brReg    = 3'd4
	} brSelT;

	// ALU operand B source
	typedef enum logic [1:0] {
		opBReg  = 2'd0,
		opBImm3 = 2'd1,
		opBImm8 = 2'd2,
		opBImm5 = 2'd3
	} opBSelT;

endpackage

// File: rtl/cpuControl.sv
// Combinational decoder; ADD/SUB imm8 is instr[10:3] so its top bits come from the opcode
`timescale 1ns/1ns

module cpuControl import cpuPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [15:0] instr,
	input  logic [3:0]  flags,
	output logic        regWrite,
	output logic        memWrite,
	output logic        memRead,
	output logic [1:0]  reg1Loc,
	output logic [1:0]  reg2Loc,
	output logic [1:0]  reg3Loc,
	output opBSelT      opBSel,
	output aluOpT       aluOp,
	output shiftKindT   shiftKind,
	output logic [3:0]  flagMask,
	output wrSelT       wrSel,
	output brSelT       brSel
);

	logic [9:0] opcode;
	logic       rdWr;
	logic       mWr;
	logic       mRd;

	assign opcode = instr[15:6];

	// Condition codes 0..14, flags ordered N Z C V
	function automatic logic condPass(input logic [3:0] cond, input logic [3:0] nzcv);
		logic n;
		logic z;
		logic c;
		logic v;
		n = nzcv[3];
		z = nzcv[2];
		c = nzcv[1];
		v = nzcv[0];
		case (cond)
			4'd0:  condPass = z;
			4'd1:  condPass = !z;
			4'd2:  condPass = c;
			4'd3:  condPass = !c;
			4'd4:  condPass = n;
			4'd5:  condPass = !n;
			4'd6:  condPass = v;
			4'd7:  condPass = !v;
			4'd8:  condPass = c && !z;
			4'd9:  condPass = !c || z;
			4'd10: condPass = (n == v);
			4'd11: condPass = (n != v);
			4'd12: condPass = !z && (n == v);
			4'd13: condPass = z || (n != v);
			4'd14: condPass = 1'b1;
			default: condPass = 1'b0;
		endcase
	endfunction

	always_comb begin
		rdWr      = 1'b0;
		mWr       = 1'b0;
		mRd       = 1'b0;
		reg1Loc   = 2'd0;
		reg2Loc   = 2'd1;
		reg3Loc   = 2'd0;
		opBSel    = opBReg;
		aluOp     = aluAdd;
		shiftKind = shLsl;
		flagMask  = 4'b0000;
		wrSel     = wrAlu;
		brSel     = brSeq;
		casez (opcode)
			// MOVS rd(2:0) = imm8
			10'b00100?????: begin
				rdWr     = 1'b1;
				opBSel   = opBImm8;
				aluOp    = aluMov;
				flagMask = 4'b1100;
				wrSel    = wrImm;
			end
			// MOV rd(2:0) = rm(5:3), flags untouched
			10'b010001100?: begin
				rdWr  = 1'b1;
				aluOp = aluMov;
			end
			10'b0001110???: begin
				rdWr     = 1'b1;
				reg1Loc  = 2'd1;
				opBSel   = opBImm3;
				flagMask = 4'b1111;
			end
			10'b0001100???: begin
				rdWr     = 1'b1;
				reg1Loc  = 2'd1;
				reg2Loc  = 2'd2;
				flagMask = 4'b1111;
			end
			10'b0001111???: begin
				rdWr     = 1'b1;
				reg1Loc  = 2'd1;
				opBSel   = opBImm3;
				aluOp    = aluSub;
				flagMask = 4'b1111;
			end
			10'b0001101???: begin
				rdWr     = 1'b1;
				reg1Loc  = 2'd1;
				reg2Loc  = 2'd2;
				aluOp    = aluSub;
				flagMask = 4'b1111;
			end
			// ADD and SUB keep the flags
			10'b10110000??: begin
				rdWr   = 1'b1;
				opBSel = opBImm8;
				aluOp  = opcode[1] ? aluSub : aluAdd;
			end
			10'b0100001010: begin
				aluOp    = aluSub;
				flagMask = 4'b1111;
			end
			10'b0100000000, 10'b0100000001, 10'b0100001100, 10'b0100001111: begin
				rdWr     = 1'b1;
				flagMask = 4'b1100;
				case (opcode[3:0])
					4'b0000: aluOp = aluAnd;
					4'b0001: aluOp = aluEor;
					4'b1100: aluOp = aluOrr;
					default: aluOp = aluMvn;
				endcase
			end
			// Shift rdn(2:0) by rm(5:3)
			10'b0100000010, 10'b0100000011, 10'b0100000100, 10'b0100000111: begin
				rdWr     = 1'b1;
				aluOp    = aluShift;
				flagMask = 4'b1100;
				wrSel    = wrShift;
				case (opcode[3:0])
					4'b0010: shiftKind = shLsl;
					4'b0011: shiftKind = shLsr;
					4'b0100: shiftKind = shAsr;
					default: shiftKind = shRor;
				endcase
			end
			// STR rt(2:0) to [rn(5:3) + imm5]
			10'b01100?????: begin
				mWr     = 1'b1;
				reg1Loc = 2'd1;
				reg2Loc = 2'd0;
				opBSel  = opBImm5;
			end
			10'b01101?????: begin
				rdWr    = 1'b1;
				mRd     = 1'b1;
				reg1Loc = 2'd1;
				opBSel  = opBImm5;
				wrSel   = wrMem;
			end
			10'b1101??????: brSel = condPass(instr[11:8], flags) ? brCond : brSeq;
			10'b11100?????: brSel = brUncond;
			10'b0100010100: begin
				rdWr    = 1'b1;
				reg3Loc = 2'd3;
				wrSel   = wrLink;
				brSel   = brLink;
			end
			// BX always returns through the link register
			10'b010001110?: begin
				reg2Loc = 2'd3;
				brSel   = brReg;
			end
			// NOOP and unused encodings just advance pc
			default: ;
		endcase
	end

	// Strobes held off while the core is in reset
	assign regWrite = rdWr && !rst;
	assign memWrite = mWr && !rst;
	assign memRead  = mRd && !rst;

	memPortExclusive: assert property (@(posedge clk) !(memWrite && memRead))
		else $error("memWrite and memRead both high");

	// Reset expects a NOOP on instr
	noWriteInReset: assert property (@(posedge clk) rst |-> !(rdWr || mWr || mRd))
		else $error("instruction with side effects presented during reset");

endmodule

// File: rtl/regFile.sv
// Eight registers, combinational reads, write on the clock edge; all cleared by reset
`timescale 1ns/1ns
`include "cpu_settings.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_REG_AW-1:0] rdAddrA,
	input  logic [`CPU_REG_AW-1:0] rdAddrB,
	input  logic [`CPU_REG_AW-1:0] wrAddr,
	input  logic                   wrEn,
	input  logic [`CPU_DATA_W-1:0] wrData,
	output logic [`CPU_DATA_W-1:0] rdA,
	output logic [`CPU_DATA_W-1:0] rdB
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// No write-through; a read in the writing cycle sees the old value
	assign rdA = regs[rdAddrA];
	assign rdB = regs[rdAddrB];

endmodule

// File: rtl/execUnit.sv
// ALU, barrel shifter and NZCV; shift amount is rdB[3:0], logic ops report C and V as 0
`timescale 1ns/1ns
`include "cpu_settings.svh"

module execUnit import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_DATA_W-1:0] rdA,
	input  logic [`CPU_DATA_W-1:0] rdB,
	input  logic [15:0]            instr,
	input  opBSelT                 opBSel,
	input  aluOpT                  aluOp,
	input  shiftKindT              shiftKind,
	input  logic [3:0]             flagMask,
	output logic [`CPU_DATA_W-1:0] aluResult,
	output logic [`CPU_DATA_W-1:0] shiftResult,
	output logic [3:0]             flags
);

	localparam int Msb = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W-1:0]   opB;
	logic [2*`CPU_DATA_W-1:0] rotWide;
	logic [3:0]               shAmt;
	logic                     carry;
	logic                     ovf;
	logic [3:0]               newFlags;

	always_comb begin
		case (opBSel)
			opBImm3: opB = `CPU_DATA_W'(instr[8:6]);
			opBImm8: opB = `CPU_DATA_W'(instr[10:3]);
			opBImm5: opB = `CPU_DATA_W'(instr[10:6]);
			default: opB = rdB;
		endcase
	end

	assign shAmt   = rdB[3:0];
	assign rotWide = {rdA, rdA} >> shAmt;

	always_comb begin
		case (shiftKind)
			shLsl:   shiftResult = rdA << shAmt;
			shLsr:   shiftResult = rdA >> shAmt;
			shAsr:   shiftResult = $signed(rdA) >>> shAmt;
			default: shiftResult = rotWide[`CPU_DATA_W-1:0];
		endcase
	end

	always_comb begin
		carry = 1'b0;
		ovf   = 1'b0;
		case (aluOp)
			aluAdd: begin
				{carry, aluResult} = {1'b0, rdA} + {1'b0, opB};
				ovf = (rdA[Msb] == opB[Msb]) && (aluResult[Msb] != rdA[Msb]);
			end
			// Carry set means no borrow
			aluSub: begin
				{carry, aluResult} = {1'b0, rdA} + {1'b0, ~opB} + 17'd1;
				ovf = (rdA[Msb] != opB[Msb]) && (aluResult[Msb] != rdA[Msb]);
			end
			aluAnd:  aluResult = rdA & opB;
			aluOrr:  aluResult = rdA | opB;
			aluEor:  aluResult = rdA ^ opB;
			aluMvn:  aluResult = ~opB;
			aluMov:  aluResult = opB;
			default: aluResult = shiftResult;
		endcase
	end

	assign newFlags = {aluResult[Msb], aluResult == '0, carry, ovf};

	// Only masked flag bits take the new value
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= 4'b0000;
		end else begin
			flags <= (flags & ~flagMask) | (newFlags & flagMask);
		end
	end

	// Subtract carry agrees with an unsigned compare
	carryNoBorrow: assert property (@(posedge clk) disable iff (rst)
		(aluOp == aluSub) |-> (carry == (rdA >= opB)))
		else $error("subtract carry disagrees with the operand compare");

endmodule

// File: rtl/pcUnit.sv
// Program counter in instruction units; all branch offsets are relative to pc+1
`timescale 1ns/1ns
`include "cpu_settings.svh"

module pcUnit import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [15:0]            instr,
	input  brSelT                  brSel,
	input  logic [`CPU_DATA_W-1:0] rdB,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic [`CPU_DATA_W-1:0] linkAddr
);

	logic [`CPU_DATA_W-1:0] pcPlus1;
	logic [`CPU_DATA_W-1:0] nextPc;

	assign pcPlus1  = pc + 1'b1;
	assign linkAddr = pcPlus1;

	// Signed offsets from the low instruction bits
	always_comb begin
		case (brSel)
			brCond:   nextPc = pcPlus1 + {{(`CPU_DATA_W-8){instr[7]}}, instr[7:0]};
			brUncond: nextPc = pcPlus1 + {{(`CPU_DATA_W-11){instr[10]}}, instr[10:0]};
			brLink:   nextPc = pcPlus1 + {{(`CPU_DATA_W-6){instr[5]}}, instr[5:0]};
			brReg:    nextPc = rdB;
			default:  nextPc = pcPlus1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

// File: rtl/cpuTop.sv
// Single-cycle core; memory must answer memRdData in the same cycle it is addressed
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuTop import cpuPkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [15:0]            instr,
	input  logic [`CPU_DATA_W-1:0] memRdData,
	output logic [`CPU_DATA_W-1:0] pc,
	output logic [`CPU_DATA_W-1:0] memAddr,
	output logic [`CPU_DATA_W-1:0] memWrData,
	output logic                   memWrite,
	output logic                   memRead
);

	logic                   regWrite;
	logic [1:0]             reg1Loc;
	logic [1:0]             reg2Loc;
	logic [1:0]             reg3Loc;
	opBSelT                 opBSel;
	aluOpT                  aluOp;
	shiftKindT              shiftKind;
	logic [3:0]             flagMask;
	wrSelT                  wrSel;
	brSelT                  brSel;
	logic [3:0]             flags;
	logic [`CPU_REG_AW-1:0] rdAddrA;
	logic [`CPU_REG_AW-1:0] rdAddrB;
	logic [`CPU_REG_AW-1:0] wrAddr;
	logic [`CPU_DATA_W-1:0] rdA;
	logic [`CPU_DATA_W-1:0] rdB;
	logic [`CPU_DATA_W-1:0] aluResult;
	logic [`CPU_DATA_W-1:0] shiftResult;
	logic [`CPU_DATA_W-1:0] linkAddr;
	logic [`CPU_DATA_W-1:0] immData;
	logic [`CPU_DATA_W-1:0] wrData;

	// Register field picked by a Loc select
	function automatic logic [`CPU_REG_AW-1:0] fieldAddr(input logic [1:0] loc,
		input logic [15:0] ins);
		case (loc)
			2'd0:    fieldAddr = ins[2:0];
			2'd1:    fieldAddr = ins[5:3];
			2'd2:    fieldAddr = ins[8:6];
			default: fieldAddr = `CPU_REG_AW'(`CPU_LINK_REG);
		endcase
	endfunction

	assign rdAddrA = fieldAddr(reg1Loc, instr);
	assign rdAddrB = fieldAddr(reg2Loc, instr);
	assign wrAddr  = fieldAddr(reg3Loc, instr);

	assign immData = `CPU_DATA_W'(instr[10:3]);
	assign wrData  = (wrSel == wrShift) ? shiftResult :
		(wrSel == wrImm)  ? immData :
		(wrSel == wrMem)  ? memRdData :
		(wrSel == wrLink) ? linkAddr : aluResult;

	assign memAddr   = aluResult;
	assign memWrData = rdB;

	cpuControl ctrl (
		.clk(clk), .rst(rst), .instr(instr), .flags(flags),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.reg1Loc(reg1Loc), .reg2Loc(reg2Loc), .reg3Loc(reg3Loc),
		.opBSel(opBSel), .aluOp(aluOp), .shiftKind(shiftKind),
		.flagMask(flagMask), .wrSel(wrSel), .brSel(brSel)
	);

	regFile regs (
		.clk(clk), .rst(rst),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .wrAddr(wrAddr),
		.wrEn(regWrite), .wrData(wrData), .rdA(rdA), .rdB(rdB)
	);

	execUnit exec (
		.clk(clk), .rst(rst), .rdA(rdA), .rdB(rdB), .instr(instr),
		.opBSel(opBSel), .aluOp(aluOp), .shiftKind(shiftKind), .flagMask(flagMask),
		.aluResult(aluResult), .shiftResult(shiftResult), .flags(flags)
	);

	pcUnit pcu (
		.clk(clk), .rst(rst), .instr(instr), .brSel(brSel), .rdB(rdB),
		.pc(pc), .linkAddr(linkAddr)
	);

endmodule

// File: tests/cpuTop_tb.sv
// Replays tests/program_trace.txt from the project root; memRdData is random unless a line marks it
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpuTop_tb;

	localparam logic [15:0] Noop = 16'hBF00;

	logic                   clk;
	logic                   rst;
	logic [15:0]            instr;
	logic [`CPU_DATA_W-1:0] memRdData;
	logic [`CPU_DATA_W-1:0] pc;
	logic [`CPU_DATA_W-1:0] memAddr;
	logic [`CPU_DATA_W-1:0] memWrData;
	logic                   memWrite;
	logic                   memRead;

	// One queue per trace column
	logic [15:0] tInstr[$];
	logic [15:0] tRdData[$];
	logic [15:0] tRdKnown[$];
	logic [15:0] tWr[$];
	logic [15:0] tRd[$];
	logic [15:0] tAddr[$];
	logic [15:0] tWrData[$];
	logic [15:0] tPc[$];

	int cycles = 0;
	int cycleLimit = 0;

	cpuTop dut (
		.clk(clk), .rst(rst), .instr(instr), .memRdData(memRdData),
		.pc(pc), .memAddr(memAddr), .memWrData(memWrData),
		.memWrite(memWrite), .memRead(memRead)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string name, input logic [`CPU_DATA_W-1:0] expVal,
		input logic [`CPU_DATA_W-1:0] actVal);
		if (actVal !== expVal) begin
			stopRun($sformatf("error at %0t: %s expected %h actual %h",
				$time, name, expVal, actVal));
		end
	endtask

	task automatic checkBit(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal) begin
			stopRun($sformatf("error at %0t: %s expected %b actual %b",
				$time, name, expVal, actVal));
		end
	endtask

	// Lines starting with # are skipped, text after the eighth field is ignored
	task automatic loadTrace();
		int          fd;
		int          code;
		string       line;
		logic [15:0] f[8];
		fd = $fopen("tests/program_trace.txt", "r");
		if (fd == 0) begin
			stopRun("cannot open the trace file tests/program_trace.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && line[0] != "#") begin
				code = $sscanf(line, "%h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (code == 8) begin
					tInstr.push_back(f[0]);
					tRdData.push_back(f[1]);
					tRdKnown.push_back(f[2]);
					tWr.push_back(f[3]);
					tRd.push_back(f[4]);
					tAddr.push_back(f[5]);
					tWrData.push_back(f[6]);
					tPc.push_back(f[7]);
				end
			end
		end
		$fclose(fd);
	endtask

	// Trace length plus reset plus some slack
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			stopRun($sformatf("run did not finish within %0d cycles", cycleLimit));
		end
	end

	initial begin
		logic [`CPU_DATA_W-1:0] expPc;
		void'($urandom(60));
		rst = 1'b1;
		instr = Noop;
		memRdData = '0;
		expPc = '0;
		loadTrace();
		if (tInstr.size() == 0) begin
			stopRun("the trace file holds no instruction lines");
		end
		cycleLimit = tInstr.size() + 2 + 10;

		// First reset edge, core must be idle at pc 0
		@(posedge clk);
		@(negedge clk);
		checkWord("pc", '0, pc);
		checkBit("memWrite", 1'b0, memWrite);
		checkBit("memRead", 1'b0, memRead);
		@(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < tInstr.size(); i++) begin
			instr <= tInstr[i];
			memRdData <= tRdKnown[i][0] ? tRdData[i] : `CPU_DATA_W'($urandom);
			@(negedge clk);
			checkWord("pc", expPc, pc);
			checkBit("memWrite", tWr[i][0], memWrite);
			checkBit("memRead", tRd[i][0], memRead);
			// Port values only matter under a strobe
			if (tWr[i][0] || tRd[i][0]) begin
				checkWord("memAddr", tAddr[i], memAddr);
			end
			if (tWr[i][0]) begin
				checkWord("memWrData", tWrData[i], memWrData);
			end
			expPc = tPc[i];
			@(posedge clk);
		end

		// Target of the last line
		instr <= Noop;
		@(negedge clk);
		checkWord("pc", expPc, pc);
		$display("TEST OK");
		$finish;
	end

endmodule

// File: tests/program_trace.txt
# instr memRdData rdKnown memWrite memRead memAddr memWrData nextPc, all hex
# memAddr is checked under either strobe, memWrData only with memWrite
22d1 0000 0 0 0 0000 0000 0001  movs r1, #0x5a
1cca 0000 0 0 0 0000 0000 0002  adds r2, r1, #3
1a53 0000 0 0 0 0000 0000 0003  subs r3, r2, r1
189c 0000 0 0 0 0000 0000 0004  adds r4, r3, r2
1fe5 0000 0 0 0 0000 0000 0005  subs r5, r4, #7
b04d 0000 0 0 0 0000 0000 0006  add r5, #9
b094 0000 0 0 0 0000 0000 0007  sub r4, #18
6105 0000 0 1 0 0004 0062 0008  str r5, [r0, #4]
604c 0000 0 1 0 005b 004e 0009  str r4, [r1, #1]
67d3 0000 0 1 0 007c 0003 000a  str r3, [r2, #31]
400d 0000 0 0 0 0000 0000 000b  ands r5, r1
4054 0000 0 0 0 0000 0000 000c  eors r4, r2
430b 0000 0 0 0 0000 0000 000d  orrs r3, r1
43ce 0000 0 0 0 0000 0000 000e  mvns r6, r1
200f 0000 0 0 0 0000 0000 000f  movs r7, #1
40bc 0000 0 0 0 0000 0000 0010  lsls r4, r7
40fd 0000 0 0 0 0000 0000 0011  lsrs r5, r7
413e 0000 0 0 0 0000 0000 0012  asrs r6, r7
41fb 0000 0 0 0 0000 0000 0013  rors r3, r7
6004 0000 0 1 0 0000 0026 0014  str r4, [r0, #0]
6045 0000 0 1 0 0001 0021 0015  str r5, [r0, #1]
6086 0000 0 1 0 0002 ffd2 0016  str r6, [r0, #2]
60c3 0000 0 1 0 0003 802d 0017  str r3, [r0, #3]
4632 0000 0 0 0 0000 0000 0018  mov r2, r6
6a41 1234 1 0 1 0009 0000 0019  ldr r1, [r0, #9]
6011 0000 0 1 0 ffd2 1234 001a  str r1, [r2, #0]
4299 0000 0 0 0 0000 0000 001b  cmp r1, r3 gives nzcv 1001
d003 0000 0 0 0 0000 0000 001c  beq
d103 0000 0 0 0 0000 0000 0020  bne
d203 0000 0 0 0 0000 0000 0021  bcs
d3fe 0000 0 0 0 0000 0000 0020  bcc -2
d405 0000 0 0 0 0000 0000 0026  bmi +5
d503 0000 0 0 0 0000 0000 0027  bpl
d601 0000 0 0 0 0000 0000 0029  bvs +1
d703 0000 0 0 0 0000 0000 002a  bvc
d803 0000 0 0 0 0000 0000 002b  bhi
d902 0000 0 0 0 0000 0000 002e  bls +2
da03 0000 0 0 0 0000 0000 0032  bge +3
db03 0000 0 0 0 0000 0000 0033  blt
dc04 0000 0 0 0 0000 0000 0038  bgt +4
dd03 0000 0 0 0 0000 0000 0039  ble
de01 0000 0 0 0 0000 0000 003b  bal +1
e010 0000 0 0 0 0000 0000 004c  b +16
4505 0000 0 0 0 0000 0000 0052  bl +5, r7 = 0x4d
6147 0000 0 1 0 0005 004d 0053  str r7, [r0, #5]
4700 0000 0 0 0 0000 0000 004d  bx
bf00 0000 0 0 0 0000 0000 004e  noop

// File: filelist.f
+incdir+include
rtl/cpuPkg.sv
rtl/cpuControl.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/pcUnit.sv
rtl/cpuTop.sv
tests/cpuTop_tb.sv

// File: Bender.yml
package:
  name: thumb_exec_core

export_include_dirs:
  - include

sources:
  - files:
      - rtl/cpuPkg.sv
      - rtl/cpuControl.sv
      - rtl/regFile.sv
      - rtl/execUnit.sv
      - rtl/pcUnit.sv
      - rtl/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_tb.sv
